//--- hw/umi_width_pkg.sv
// UMI width adapter definitions
// Bus widths, FIFO sizing and command field positions shared by the adapter

package umi_width_pkg;

   // ##########################################################################
   // Bus widths
   // ##########################################################################

   localparam int CW     = 32;         // UMI command word
   localparam int AW     = 64;         // Address, same on both sides
   localparam int IDW    = 256;        // Wide input data
   localparam int ODW    = 64;         // Narrow output data
   localparam int OBYTES = ODW / 8;    // Bytes per output beat

   // ##########################################################################
   // FIFO sizing
   // ##########################################################################

   localparam int DEPTH  = 4;
   localparam int PTRW   = 2;          // log2 of DEPTH
   localparam int FIFO_W = CW + 2*AW + ODW;

   // One entry, LSB first: cmd, dstaddr, srcaddr, data

   // ##########################################################################
   // UMI command fields
   // ##########################################################################

   localparam int CMD_OPCODE_LSB = 0;  // 5 bits
   localparam int CMD_SIZE_LSB   = 5;
   localparam int CMD_SIZE_W     = 3;
   localparam int CMD_LEN_LSB    = 8;
   localparam int CMD_LEN_W      = 8;
   localparam int CMD_EOM_LSB    = 22; // Single bit

   // Remaining cmd bits (atype, qos, prot, user...) are never touched

   // ##########################################################################
   // Chaos LFSR
   // ##########################################################################

   localparam int LFSR_W = 16;

   // Bit 0 clear so chaos cannot report full on the first cycle
   localparam logic [LFSR_W-1:0] LFSR_SEED = 16'h7a3c;

endpackage

//--- hw/umi_width_splitter.sv
// UMI width splitter
// Breaks one wide UMI transaction into a train of narrow pieces, each with
// its own len, eom and advanced addresses

`timescale 1ns/10ps

module umi_width_splitter
  (
   input  logic                             umi_in_clk,
   input  logic                             umi_in_nreset,
   // Wide input
   input  logic                             in_valid,
   input  logic [umi_width_pkg::CW-1:0]     in_cmd,
   input  logic [umi_width_pkg::AW-1:0]     in_dstaddr,
   input  logic [umi_width_pkg::AW-1:0]     in_srcaddr,
   input  logic [umi_width_pkg::IDW-1:0]    in_data,
   output logic                             in_ready,
   // FIFO write side
   output logic                             wr_en,
   output logic [umi_width_pkg::FIFO_W-1:0] wr_din,
   input  logic                             wr_full
   );

   import umi_width_pkg::*;

   // Remainder of a transaction still to be sent
   logic                  rem_valid;
   logic [CW-1:0]         rem_cmd;
   logic [AW-1:0]         rem_dstaddr;
   logic [AW-1:0]         rem_srcaddr;
   logic [IDW-1:0]        rem_data;

   // Source of the current piece
   logic [CW-1:0]         cur_cmd;
   logic [AW-1:0]         cur_dstaddr;
   logic [AW-1:0]         cur_srcaddr;
   logic [IDW-1:0]        cur_data;

   // Length arithmetic
   logic [CMD_SIZE_W-1:0] cur_size;
   logic [CMD_LEN_W-1:0]  cur_len;
   logic [CMD_LEN_W:0]    cur_total;
   logic [CMD_LEN_W:0]    beat_elems;
   logic [CMD_LEN_W:0]    rest_total;
   logic [CMD_LEN_W-1:0]  piece_len;
   logic [CMD_LEN_W-1:0]  rest_len;
   logic                  multi;

   logic [CW-1:0]         piece_cmd;
   logic [CW-1:0]         rest_cmd;
   logic                  wr_beat;

   // ##########################################################################
   // Piece source select
   // ##########################################################################

   // Remainder always goes first, fresh input only when nothing is held
   assign cur_cmd     = rem_valid ? rem_cmd     : in_cmd;
   assign cur_dstaddr = rem_valid ? rem_dstaddr : in_dstaddr;
   assign cur_srcaddr = rem_valid ? rem_srcaddr : in_srcaddr;
   assign cur_data    = rem_valid ? rem_data    : in_data;

   assign cur_size = cur_cmd[CMD_SIZE_LSB +: CMD_SIZE_W];
   assign cur_len  = cur_cmd[CMD_LEN_LSB +: CMD_LEN_W];

   // ##########################################################################
   // Splitting rule
   // ##########################################################################

   // Elements that fit into one narrow beat at this size
   assign beat_elems = (CMD_LEN_W+1)'(OBYTES) >> cur_size;

   assign cur_total  = {1'b0, cur_len} + 1'b1;        // len is count minus one
   assign multi      = cur_total > beat_elems;        // More pieces to follow
   assign rest_total = cur_total - beat_elems;

   assign piece_len = multi ? beat_elems[CMD_LEN_W-1:0] - 1'b1 : cur_len;
   assign rest_len  = rest_total[CMD_LEN_W-1:0] - 1'b1;

   always_comb
   begin
      piece_cmd                                = cur_cmd;
      piece_cmd[CMD_LEN_LSB +: CMD_LEN_W]      = piece_len;
      piece_cmd[CMD_EOM_LSB]                   = cur_cmd[CMD_EOM_LSB] & ~multi;
   end

   // Remainder keeps the original eom for its own last piece
   always_comb
   begin
      rest_cmd                                 = cur_cmd;
      rest_cmd[CMD_LEN_LSB +: CMD_LEN_W]       = rest_len;
   end

   // ##########################################################################
   // FIFO write and input handshake
   // ##########################################################################

   assign wr_en   = rem_valid | in_valid;
   assign wr_beat = wr_en & ~wr_full;

   // Input is blocked while a remainder is pending
   assign in_ready = ~rem_valid & ~wr_full;

   assign wr_din = {cur_data[ODW-1:0], cur_srcaddr, cur_dstaddr, piece_cmd};

   // ##########################################################################
   // Remainder registers
   // ##########################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_valid <= 1'b0;
      else if (wr_beat)
         rem_valid <= multi;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_beat && multi)
      begin
         rem_cmd     <= rest_cmd;
         rem_dstaddr <= cur_dstaddr + AW'(OBYTES);
         rem_srcaddr <= cur_srcaddr + AW'(OBYTES);
         rem_data    <= cur_data >> ODW;         // Next beat into the low lane
      end
   end

endmodule

//--- hw/umi_sync_fifo.sv
// Single clock FIFO for narrow UMI pieces
// Flop storage with wrap-bit pointers; chaos LFSR can fake a full FIFO

`timescale 1ns/10ps

module umi_sync_fifo
  (
   input  logic                             umi_in_clk,
   input  logic                             umi_in_nreset,
   input  logic                             chaosmode,
   // Write side
   input  logic                             wr_en,
   input  logic [umi_width_pkg::FIFO_W-1:0] wr_din,
   output logic                             wr_full,
   // Read side
   input  logic                             rd_en,
   output logic [umi_width_pkg::FIFO_W-1:0] rd_dout,
   output logic                             rd_empty
   );

   import umi_width_pkg::*;

   logic [FIFO_W-1:0] mem [DEPTH];
   logic [PTRW:0]     wr_ptr;           // MSB is the wrap bit
   logic [PTRW:0]     rd_ptr;
   logic              full_int;
   logic              do_write;
   logic              do_read;
   logic [LFSR_W-1:0] lfsr;
   logic              lfsr_fb;

   // ##########################################################################
   // Status
   // ##########################################################################

   assign rd_empty = (wr_ptr == rd_ptr);
   assign full_int = (wr_ptr[PTRW] != rd_ptr[PTRW]) &&
                     (wr_ptr[PTRW-1:0] == rd_ptr[PTRW-1:0]);

   // Pseudo-random pushback, only ever adds to the real full
   assign wr_full = full_int | (chaosmode & lfsr[0]);

   assign do_write = wr_en & ~wr_full;
   assign do_read  = rd_en & ~rd_empty;

   // ##########################################################################
   // Pointers
   // ##########################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + {{PTRW{1'b0}}, 1'b1};
         if (do_read)
            rd_ptr <= rd_ptr + {{PTRW{1'b0}}, 1'b1};
      end
   end

   // ##########################################################################
   // Storage
   // ##########################################################################

   always_ff @(posedge umi_in_clk)
   begin
      if (do_write)
         mem[wr_ptr[PTRW-1:0]] <= wr_din;
   end

   // Head entry straight out of the storage flops
   assign rd_dout = mem[rd_ptr[PTRW-1:0]];

   // ##########################################################################
   // Chaos LFSR
   // ##########################################################################

   // x^16 + x^14 + x^13 + x^11
   assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         lfsr <= LFSR_SEED;
      else
         lfsr <= {lfsr[LFSR_W-2:0], lfsr_fb};   // Free running
   end

endmodule

//--- hw/umi_fifo_width.sv
// UMI FIFO with width change
// Splits wide UMI transactions into narrow ones through a small FIFO,
// with a combinational bypass path

`timescale 1ns/10ps

module umi_fifo_width
  (
   input  logic                          umi_in_clk,
   input  logic                          umi_in_nreset,
   // Control and status
   input  logic                          bypass,      // Straight through, no FIFO
   input  logic                          chaosmode,   // Random FIFO pushback
   output logic                          fifo_full,
   output logic                          fifo_empty,
   // Wide input
   input  logic                          umi_in_valid,
   input  logic [umi_width_pkg::CW-1:0]  umi_in_cmd,
   input  logic [umi_width_pkg::AW-1:0]  umi_in_dstaddr,
   input  logic [umi_width_pkg::AW-1:0]  umi_in_srcaddr,
   input  logic [umi_width_pkg::IDW-1:0] umi_in_data,
   output logic                          umi_in_ready,
   // Narrow output
   output logic                          umi_out_valid,
   output logic [umi_width_pkg::CW-1:0]  umi_out_cmd,
   output logic [umi_width_pkg::AW-1:0]  umi_out_dstaddr,
   output logic [umi_width_pkg::AW-1:0]  umi_out_srcaddr,
   output logic [umi_width_pkg::ODW-1:0] umi_out_data,
   input  logic                          umi_out_ready
   );

   import umi_width_pkg::*;

   logic              split_in_valid;
   logic              split_in_ready;
   logic              wr_en;
   logic [FIFO_W-1:0] wr_din;
   logic              wr_full;
   logic              rd_en;
   logic [FIFO_W-1:0] rd_dout;
   logic              rd_empty;

   // FIFO head fields
   logic [CW-1:0]     fifo_cmd;
   logic [AW-1:0]     fifo_dstaddr;
   logic [AW-1:0]     fifo_srcaddr;
   logic [ODW-1:0]    fifo_data;

   // Nothing enters the splitter while bypassed
   assign split_in_valid = umi_in_valid & ~bypass;

   umi_width_splitter u_splitter
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (split_in_valid),
      .in_cmd        (umi_in_cmd),
      .in_dstaddr    (umi_in_dstaddr),
      .in_srcaddr    (umi_in_srcaddr),
      .in_data       (umi_in_data),
      .in_ready      (split_in_ready),
      .wr_en         (wr_en),
      .wr_din        (wr_din),
      .wr_full       (wr_full));

   assign rd_en = umi_out_ready & ~rd_empty & ~bypass;

   umi_sync_fifo u_fifo
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .chaosmode     (chaosmode),
      .wr_en         (wr_en),
      .wr_din        (wr_din),
      .wr_full       (wr_full),
      .rd_en         (rd_en),
      .rd_dout       (rd_dout),
      .rd_empty      (rd_empty));

   // ##########################################################################
   // Output unpack and bypass select
   // ##########################################################################

   assign fifo_cmd     = rd_dout[0 +: CW];
   assign fifo_dstaddr = rd_dout[CW +: AW];
   assign fifo_srcaddr = rd_dout[CW+AW +: AW];
   assign fifo_data    = rd_dout[CW+2*AW +: ODW];

   assign umi_out_valid   = bypass ? umi_in_valid          : ~rd_empty;
   assign umi_out_cmd     = bypass ? umi_in_cmd            : fifo_cmd;
   assign umi_out_dstaddr = bypass ? umi_in_dstaddr        : fifo_dstaddr;
   assign umi_out_srcaddr = bypass ? umi_in_srcaddr        : fifo_srcaddr;
   assign umi_out_data    = bypass ? umi_in_data[ODW-1:0]  : fifo_data;
   assign umi_in_ready    = bypass ? umi_out_ready         : split_in_ready;

   assign fifo_full  = wr_full;
   assign fifo_empty = rd_empty;

endmodule

//--- verif/umi_width_ref.svh
// UMI width adapter reference model
// Predicts the narrow pieces of each wide beat and compares DUT results

`ifndef UMI_WIDTH_REF_SVH
`define UMI_WIDTH_REF_SVH

// Expected pieces, oldest first
logic [CW-1:0]  exp_cmd[$];
logic [AW-1:0]  exp_dst[$];
logic [AW-1:0]  exp_src[$];
logic [ODW-1:0] exp_data[$];

// Splits one accepted wide beat into the pieces the output must show
function automatic void predict_pieces(input logic [CW-1:0]  cmd,
                                       input logic [AW-1:0]  dst,
                                       input logic [AW-1:0]  src,
                                       input logic [IDW-1:0] data);
   int            per_beat;
   int            remain;
   logic [CW-1:0] piece;
   per_beat = OBYTES >> cmd[CMD_SIZE_LSB +: CMD_SIZE_W];
   remain   = cmd[CMD_LEN_LSB +: CMD_LEN_W] + 1;     // Element count
   while (remain > per_beat)
   begin
      piece                              = cmd;
      piece[CMD_LEN_LSB +: CMD_LEN_W]    = CMD_LEN_W'(per_beat - 1);
      piece[CMD_EOM_LSB]                 = 1'b0;    // Not the last piece
      exp_cmd.push_back(piece);
      exp_dst.push_back(dst);
      exp_src.push_back(src);
      exp_data.push_back(data[ODW-1:0]);
      remain = remain - per_beat;
      data   = data >> ODW;
      dst    = dst + OBYTES;
      src    = src + OBYTES;
   end
   piece                           = cmd;           // Last piece keeps eom
   piece[CMD_LEN_LSB +: CMD_LEN_W] = CMD_LEN_W'(remain - 1);
   exp_cmd.push_back(piece);
   exp_dst.push_back(dst);
   exp_src.push_back(src);
   exp_data.push_back(data[ODW-1:0]);
endfunction

task automatic check_cmd(input string name, input logic [CW-1:0] expected,
                         input logic [CW-1:0] actual);
   if (actual !== expected)
   begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_on_error();
   end
endtask

task automatic check_addr(input string name, input logic [AW-1:0] expected,
                          input logic [AW-1:0] actual);
   if (actual !== expected)
   begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_on_error();
   end
endtask

task automatic check_data(input string name, input logic [ODW-1:0] expected,
                          input logic [ODW-1:0] actual);
   if (actual !== expected)
   begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_on_error();
   end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
   if (actual !== expected)
   begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
      stop_on_error();
   end
endtask

`endif

//--- verif/tb_umi_fifo_width.sv
// Testbench for the UMI width adapter
// Random wide beats checked piece by piece, with back-pressure, chaos and bypass

`timescale 1ns/10ps

module tb_umi_fifo_width;

   import umi_width_pkg::*;

   localparam int CYCLE_NS  = 20;
   localparam int NUM_BEATS = 146;   // Sum of all stimulus beats below

   logic           umi_in_clk;
   logic           umi_in_nreset;
   logic           bypass;
   logic           chaosmode;
   logic           fifo_full;
   logic           fifo_empty;
   logic           umi_in_valid;
   logic [CW-1:0]  umi_in_cmd;
   logic [AW-1:0]  umi_in_dstaddr;
   logic [AW-1:0]  umi_in_srcaddr;
   logic [IDW-1:0] umi_in_data;
   logic           umi_in_ready;
   logic           umi_out_valid;
   logic [CW-1:0]  umi_out_cmd;
   logic [AW-1:0]  umi_out_dstaddr;
   logic [AW-1:0]  umi_out_srcaddr;
   logic [ODW-1:0] umi_out_data;
   logic           umi_out_ready;
   logic           stall_en;         // Random gaps on umi_out_ready
   int             chaos_stalls;

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "Stopping at first error");
   endtask

`include "umi_width_ref.svh"

   umi_fifo_width u_umi_fifo_width (.*);

   initial
   begin
      umi_in_clk = 1'b0;
      forever #(CYCLE_NS/2) umi_in_clk = ~umi_in_clk;
   end

   initial
   begin
      #(CYCLE_NS * (NUM_BEATS * 20 + 500));
      $display("Timeout, the DUT stopped making progress");
      stop_on_error();
   end

   always @(posedge umi_in_clk)
   begin
      #1;
      umi_out_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
   end

   // ##########################################################################
   // Scoreboard, sampled mid-cycle where everything is settled
   // ##########################################################################

   always @(negedge umi_in_clk)
   begin
      if (umi_in_nreset && bypass)
      begin
         check_cmd("umi_out_cmd", umi_in_cmd, umi_out_cmd);
         check_addr("umi_out_dstaddr", umi_in_dstaddr, umi_out_dstaddr);
         check_addr("umi_out_srcaddr", umi_in_srcaddr, umi_out_srcaddr);
         check_data("umi_out_data", umi_in_data[ODW-1:0], umi_out_data);
         check_flag("umi_out_valid", umi_in_valid, umi_out_valid);
         check_flag("umi_in_ready", umi_out_ready, umi_in_ready);
      end
      else if (umi_in_nreset)
      begin
         if (umi_out_valid && umi_out_ready && exp_cmd.size() == 0)
         begin
            $display("Output piece at %0t with nothing expected", $time);
            stop_on_error();
         end
         else if (umi_out_valid && umi_out_ready)
         begin
            check_cmd("umi_out_cmd", exp_cmd.pop_front(), umi_out_cmd);
            check_addr("umi_out_dstaddr", exp_dst.pop_front(), umi_out_dstaddr);
            check_addr("umi_out_srcaddr", exp_src.pop_front(), umi_out_srcaddr);
            check_data("umi_out_data", exp_data.pop_front(), umi_out_data);
         end
         if (umi_in_valid && umi_in_ready)
            predict_pieces(umi_in_cmd, umi_in_dstaddr, umi_in_srcaddr, umi_in_data);
         if (chaosmode && fifo_full && fifo_empty && !umi_in_ready)
            chaos_stalls++;                      // Full reported with space left
      end
   end

   // ##########################################################################
   // Stimulus
   // ##########################################################################

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic send_beat(input logic [CW-1:0] cmd, input logic [AW-1:0] dst,
                            input logic [AW-1:0] src, input logic [IDW-1:0] data);
      umi_in_valid   = 1'b1;
      umi_in_cmd     = cmd;
      umi_in_dstaddr = dst;
      umi_in_srcaddr = src;
      umi_in_data    = data;
      @(negedge umi_in_clk);
      while (!umi_in_ready)
         @(negedge umi_in_clk);
      @(posedge umi_in_clk);
      #1;
      umi_in_valid = 1'b0;
   endtask

   // Random size and length, at most max_bytes in total
   task automatic run_random(input int count, input int max_bytes);
      logic [CW-1:0]  cmd;
      logic [IDW-1:0] data;
      int             size;
      int             i;
      repeat (count)
      begin
         size = $urandom_range(3);
         cmd  = $urandom;
         cmd[CMD_SIZE_LSB +: CMD_SIZE_W] = CMD_SIZE_W'(size);
         cmd[CMD_LEN_LSB +: CMD_LEN_W]   = CMD_LEN_W'($urandom_range((max_bytes >> size) - 1));
         for (i = 0; i < IDW/32; i++)
            data[i*32 +: 32] = $urandom;
         send_beat(cmd, {$urandom, $urandom}, {$urandom, $urandom}, data);
      end
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while ((exp_cmd.size() != 0 || !fifo_empty) && cycles < 400)
      begin
         @(posedge umi_in_clk);
         #1;
         cycles++;
      end
   endtask

   initial
   begin
      int unsigned seed_draw;
      seed_draw      = $urandom(32'h3f01384f);
      {bypass, chaosmode, stall_en, umi_in_valid} = '0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b1;
      chaos_stalls   = 0;
      umi_in_nreset  = 1'b0;
      repeat (3) @(posedge umi_in_clk);
      #1;
      umi_in_nreset = 1'b1;
      @(negedge umi_in_clk);
      check_flag("umi_out_valid", 1'b0, umi_out_valid);
      check_flag("fifo_empty", 1'b1, fifo_empty);
      check_flag("fifo_full", 1'b0, fifo_full);
      check_flag("umi_in_ready", 1'b1, umi_in_ready);
      @(posedge umi_in_clk);
      #1;
      run_random(16, OBYTES);                   // Single piece each
      run_random(40, IDW/8);
      stall_en = 1'b1;
      run_random(40, IDW/8);
      stall_en = 1'b0;
      chaosmode = 1'b1;
      run_random(30, IDW/8);
      wait_drained();
      chaosmode = 1'b0;
      bypass    = 1'b1;
      stall_en  = 1'b1;
      run_random(20, IDW/8);
      bypass   = 1'b0;
      stall_en = 1'b0;
      wait_drained();
      if (exp_cmd.size() != 0 || chaos_stalls == 0)
      begin
         if (exp_cmd.size() != 0)
            $display("%0d expected pieces never came out", exp_cmd.size());
         if (chaos_stalls == 0)
            $display("Chaos mode never held off the input while the FIFO was empty");
         $display("Test failed");
         $fatal(1, "Run ended with errors");
      end
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

//--- all.f
+incdir+verif
hw/umi_width_pkg.sv
hw/umi_width_splitter.sv
hw/umi_sync_fifo.sv
hw/umi_fifo_width.sv
verif/tb_umi_fifo_width.sv

//--- Bender.yml
package:
  name: umi_fifo_width

sources:
  - hw/umi_width_pkg.sv
  - hw/umi_width_splitter.sv
  - hw/umi_sync_fifo.sv
  - hw/umi_fifo_width.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_umi_fifo_width.sv
